/* tb.f */
+incdir+test
src/rob_cfg_pkg.sv
src/rob_entry_pkg.sv
src/multiport_table.sv
src/complete_table.sv
src/rob_pointers.sv
src/rob.sv
src/commit_stage.sv
src/rob_top.sv
test/tb_rob.sv

/* test/tb_rob_util.svh */
`ifndef TB_ROB_UTIL_SVH
`define TB_ROB_UTIL_SVH

logic [31:0] lfsr_state;

//////////////////////////////
// random bits
//////////////////////////////

// fibonacci form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        val        = {val[30:0], lfsr_state[0]};
    end
    return val;
endfunction

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

//////////////////////////////
// drive tasks
//////////////////////////////

task automatic drive_idle();
    dispatch_valid_i = '0;
    dispatch_w_reg_i = '0;
    cdb_valid_i      = '0;
    cdb_exc_i        = '0;
    for (int k = 0; k < 2; k++) begin
        dispatch_rob_id_i[k] = '0;
        dispatch_areg_i[k]   = '0;
        dispatch_pc_i[k]     = '0;
        cdb_rob_id_i[k]      = '0;
        cdb_data_i[k]        = '0;
    end
    for (int s = 0; s < 4; s++) begin
        src_rob_id_i[s] = '0;
    end
endtask

// reset released on a falling edge
task automatic reset_dut();
    rst_n_i = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
endtask

task automatic drive_dispatch_slot(input int k, input rob_id_t id,
                                   input logic [AREG_WIDTH-1:0] areg, input logic w_reg,
                                   input logic [PC_WIDTH-1:0] pc);
    dispatch_valid_i[k]  = 1'b1;
    dispatch_rob_id_i[k] = id;
    dispatch_areg_i[k]   = areg;
    dispatch_w_reg_i[k]  = w_reg;
    dispatch_pc_i[k]     = pc;
endtask

task automatic drive_cdb_bus(input int k, input rob_id_t id,
                             input logic [DATA_WIDTH-1:0] data, input logic exc);
    cdb_valid_i[k]  = 1'b1;
    cdb_rob_id_i[k] = id;
    cdb_data_i[k]   = data;
    cdb_exc_i[k]    = exc;
endtask

`endif

/* test/tb_rob.sv */
module tb_rob
    import rob_cfg_pkg::*;
();

    localparam int          CLK_PERIOD    = 8;
    localparam int          RESET_CYCLES  = 10;
    localparam int          RUN_CYCLES    = 1500;
    localparam int          DRAIN_TIMEOUT = 200;
    localparam logic [31:0] LFSR_SEED     = 32'h86a557dd;

    logic                  clk;
    logic                  rst_n_i;
    logic [1:0]            dispatch_valid_i;
    rob_id_t               dispatch_rob_id_i [2];
    logic [AREG_WIDTH-1:0] dispatch_areg_i [2];
    logic [1:0]            dispatch_w_reg_i;
    logic [PC_WIDTH-1:0]   dispatch_pc_i [2];
    rob_cnt_t              rob_free_o;
    rob_id_t               src_rob_id_i [4];
    logic [DATA_WIDTH-1:0] src_data_o [4];
    logic [3:0]            src_ready_o;
    logic [1:0]            cdb_valid_i;
    rob_id_t               cdb_rob_id_i [2];
    logic [DATA_WIDTH-1:0] cdb_data_i [2];
    logic [1:0]            cdb_exc_i;
    logic [1:0]            retire_valid_o;
    logic [AREG_WIDTH-1:0] retire_areg_o [2];
    logic [DATA_WIDTH-1:0] retire_data_o [2];
    logic [PC_WIDTH-1:0]   retire_pc_o [2];
    logic                  flush_o;

    // reference model in program order with fields per entry
    int                    order_q [$];
    rob_id_t               next_id;
    logic [AREG_WIDTH-1:0] m_areg [ROB_DEPTH];
    logic [PC_WIDTH-1:0]   m_pc [ROB_DEPTH];
    logic [DATA_WIDTH-1:0] m_data [ROB_DEPTH];
    logic                  m_done [ROB_DEPTH];
    logic                  m_exc [ROB_DEPTH];
    logic                  m_oldest [ROB_DEPTH];
    int                    m_cdb_cyc [ROB_DEPTH];
    int                    cyc;
    int                    n_flush;
    int                    n_full;

    rob_top i_dut (.*);

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s = %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    `include "tb_rob_util.svh"

    task automatic clear_model();
        order_q.delete();
        next_id = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            m_done[i]   = 1'b0;
            m_exc[i]    = 1'b0;
            m_oldest[i] = 1'b0;
        end
    endtask

    //////////////////////////////
    // one clock cycle
    //////////////////////////////

    // check what the last edge produced, then drive the next one
    task automatic step_cycle(input bit disp_on, input bit cdb_on);
        logic    exp_flush;
        int      cand [$];
        int      n;
        int      idx;
        rob_id_t id;
        @(negedge clk);
        cyc++;
        exp_flush = 1'b0;
        assert (retire_valid_o != 2'b10) else begin
            $display("slot 1 retired while slot 0 did not");
            stop_run();
        end
        for (int k = 0; k < 2; k++) begin
            if (retire_valid_o[k]) begin
                assert (order_q.size() > 0 && m_done[order_q[0]]) else begin
                    $display("retire on slot %0d without a completed oldest entry", k);
                    stop_run();
                end
                id = rob_id_t'(order_q.pop_front());
                expect_equal($sformatf("retire_areg_o[%0d]", k), retire_areg_o[k], m_areg[id]);
                expect_equal($sformatf("retire_data_o[%0d]", k), retire_data_o[k], m_data[id]);
                expect_equal($sformatf("retire_pc_o[%0d]", k), retire_pc_o[k], m_pc[id]);
                // oldest at its CDB edge, so the strobe follows one cycle later
                if (m_oldest[id]) begin
                    expect_equal("cycles from CDB edge to retire", cyc - m_cdb_cyc[id] - 1, 1);
                end
                if (k == 0 && m_exc[id]) begin
                    expect_equal("retire_valid_o[1]", retire_valid_o[1], 0);
                end
                exp_flush |= m_exc[id];
            end
        end
        expect_equal("flush_o", flush_o, exp_flush);
        expect_equal("rob_free_o", rob_free_o, ROB_DEPTH - order_q.size());
        for (int s = 0; s < 4; s++) begin
            expect_equal($sformatf("src_ready_o[%0d]", s), src_ready_o[s],
                         m_done[src_rob_id_i[s]]);
            if (m_done[src_rob_id_i[s]]) begin
                expect_equal($sformatf("src_data_o[%0d]", s), src_data_o[s],
                             m_data[src_rob_id_i[s]]);
            end
        end
        drive_idle();
        for (int s = 0; s < 4; s++) begin
            src_rob_id_i[s] = rob_id_t'(take_bits(ROB_WIDTH));
        end
        if (flush_o) begin
            // the coming edge clears everything and ids restart at 0
            n_flush++;
            clear_model();
            return;
        end
        // results in any order among the outstanding entries
        for (int i = 0; i < order_q.size(); i++) begin
            if (!m_done[order_q[i]]) begin
                cand.push_back(order_q[i]);
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (cdb_on && cand.size() > 0 && take_bits(2) != 0) begin
                idx = int'(take_bits(4)) % cand.size();
                id  = rob_id_t'(cand[idx]);
                cand.delete(idx);
                m_done[id]    = 1'b1;
                m_data[id]    = take_bits(DATA_WIDTH);
                m_exc[id]     = (take_bits(5) == 0);
                m_oldest[id]  = (id == order_q[0]);
                m_cdb_cyc[id] = cyc;
                drive_cdb_bus(k, id, m_data[id], m_exc[id]);
            end
        end
        n = disp_on ? int'(take_bits(2)) % 3 : 0;
        if (n > int'(rob_free_o)) begin
            // hold the group until there is room
            n = 0;
            n_full += (rob_free_o == 0);
        end
        for (int k = 0; k < n; k++) begin
            id         = next_id;
            next_id    = next_id + 1'b1;
            m_areg[id] = AREG_WIDTH'(take_bits(AREG_WIDTH));
            m_pc[id]   = take_bits(PC_WIDTH);
            m_done[id] = 1'b0;
            order_q.push_back(id);
            drive_dispatch_slot(k, id, m_areg[id], take_bits(1) != 0, m_pc[id]);
        end
    endtask

    initial begin
        lfsr_state = LFSR_SEED;
        cyc        = 0;
        n_flush    = 0;
        n_full     = 0;
        clear_model();
        reset_dut();
        expect_equal("retire_valid_o", retire_valid_o, 0);
        expect_equal("flush_o", flush_o, 0);
        expect_equal("rob_free_o", rob_free_o, ROB_DEPTH);
        // results held back for 40 of every 200 cycles, so the ROB fills
        for (int c = 0; c < RUN_CYCLES; c++) begin
            step_cycle(1'b1, (c % 200) >= 40);
        end
        for (int t = 0; order_q.size() > 0; t++) begin
            assert (t < DRAIN_TIMEOUT) else begin
                $display("ROB did not drain within %0d cycles", DRAIN_TIMEOUT);
                stop_run();
            end
            step_cycle(1'b0, 1'b1);
        end
        // idle tail catches stray retire strobes
        repeat (4) step_cycle(1'b0, 1'b0);
        if (n_flush > 0 && n_full > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("stimulus never reached an exception flush or a full ROB");
            stop_run();
        end
    end

endmodule

/* src/rob_top.sv */
module rob_top
    import rob_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,

    input  logic [1:0]            dispatch_valid_i,
    input  rob_id_t               dispatch_rob_id_i [2],
    input  logic [AREG_WIDTH-1:0] dispatch_areg_i [2],
    input  logic [1:0]            dispatch_w_reg_i,
    input  logic [PC_WIDTH-1:0]   dispatch_pc_i [2],
    output rob_cnt_t              rob_free_o,

    input  rob_id_t               src_rob_id_i [4],
    output logic [DATA_WIDTH-1:0] src_data_o [4],
    output logic [3:0]            src_ready_o,

    input  logic [1:0]            cdb_valid_i,
    input  rob_id_t               cdb_rob_id_i [2],
    input  logic [DATA_WIDTH-1:0] cdb_data_i [2],
    input  logic [1:0]            cdb_exc_i,

    output logic [1:0]            retire_valid_o,
    output logic [AREG_WIDTH-1:0] retire_areg_o [2],
    output logic [DATA_WIDTH-1:0] retire_data_o [2],
    output logic [PC_WIDTH-1:0]   retire_pc_o [2],
    output logic                  flush_o
);

    logic [1:0]            commit_req;
    logic [1:0]            head_valid;
    logic [AREG_WIDTH-1:0] head_areg [2];
    logic [1:0]            head_w_reg;
    logic [PC_WIDTH-1:0]   head_pc [2];
    logic [DATA_WIDTH-1:0] head_data [2];
    logic [1:0]            head_exc;

    // flush loops back into the ROB
    rob i_rob (
        .clk (clk), .rst_n_i (rst_n_i), .flush_i (flush_o),
        .dispatch_valid_i (dispatch_valid_i), .dispatch_rob_id_i (dispatch_rob_id_i),
        .dispatch_areg_i (dispatch_areg_i), .dispatch_w_reg_i (dispatch_w_reg_i),
        .dispatch_pc_i (dispatch_pc_i), .src_rob_id_i (src_rob_id_i),
        .src_data_o (src_data_o), .src_ready_o (src_ready_o),
        .cdb_valid_i (cdb_valid_i), .cdb_rob_id_i (cdb_rob_id_i),
        .cdb_data_i (cdb_data_i), .cdb_exc_i (cdb_exc_i), .rob_free_o (rob_free_o),
        .commit_req_i (commit_req), .head_valid_o (head_valid), .head_areg_o (head_areg),
        .head_w_reg_o (head_w_reg), .head_pc_o (head_pc), .head_data_o (head_data),
        .head_exc_o (head_exc)
    );

    commit_stage i_commit (
        .clk (clk), .rst_n_i (rst_n_i),
        .head_valid_i (head_valid), .head_areg_i (head_areg), .head_w_reg_i (head_w_reg),
        .head_pc_i (head_pc), .head_data_i (head_data), .head_exc_i (head_exc),
        .commit_req_o (commit_req), .retire_valid_o (retire_valid_o),
        .retire_areg_o (retire_areg_o), .retire_data_o (retire_data_o),
        .retire_pc_o (retire_pc_o), .flush_o (flush_o)
    );

endmodule

/* src/commit_stage.sv */
module commit_stage
    import rob_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,

    input  logic [1:0]            head_valid_i,
    input  logic [AREG_WIDTH-1:0] head_areg_i [2],
    input  logic [1:0]            head_w_reg_i,
    input  logic [PC_WIDTH-1:0]   head_pc_i [2],
    input  logic [DATA_WIDTH-1:0] head_data_i [2],
    input  logic [1:0]            head_exc_i,

    output logic [1:0]            commit_req_o,
    output logic [1:0]            retire_valid_o,
    output logic [AREG_WIDTH-1:0] retire_areg_o [2],
    output logic [DATA_WIDTH-1:0] retire_data_o [2],
    output logic [PC_WIDTH-1:0]   retire_pc_o [2],
    output logic                  flush_o
);

    logic [DATA_WIDTH-1:0] arf [1 << AREG_WIDTH];
    logic                  flush_q;

    // in order; an exception in slot 0 holds slot 1 back
    // nothing commits while the flush is in flight
    assign commit_req_o[0] = head_valid_i[0] && !flush_q;
    assign commit_req_o[1] = commit_req_o[0] && !head_exc_i[0] && head_valid_i[1];

    ////////////////////////////////
    // architectural registers
    ////////////////////////////////

    // slot 1 is younger, its write lands last
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (commit_req_o[k] && head_w_reg_i[k] && (head_areg_i[k] != '0)) begin
                arf[head_areg_i[k]] <= head_data_i[k];
            end
        end
    end

    ////////////////////////////////
    // retire strobe and flush
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_valid_o <= '0;
            flush_q        <= 1'b0;
        end else begin
            retire_valid_o <= commit_req_o;
            flush_q        <= |(commit_req_o & head_exc_i);
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            retire_areg_o[k] <= head_areg_i[k];
            retire_data_o[k] <= head_data_i[k];
            retire_pc_o[k]   <= head_pc_i[k];
        end
    end

    assign flush_o = flush_q;

endmodule

/* src/rob.sv */
module rob
    import rob_cfg_pkg::*;
    import rob_entry_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // dispatch, slot 0 older
    input  logic [1:0]            dispatch_valid_i,
    input  rob_id_t               dispatch_rob_id_i [2],
    input  logic [AREG_WIDTH-1:0] dispatch_areg_i [2],
    input  logic [1:0]            dispatch_w_reg_i,
    input  logic [PC_WIDTH-1:0]   dispatch_pc_i [2],

    // source operand lookups
    input  rob_id_t               src_rob_id_i [4],
    output logic [DATA_WIDTH-1:0] src_data_o [4],
    output logic [3:0]            src_ready_o,

    // result buses
    input  logic [1:0]            cdb_valid_i,
    input  rob_id_t               cdb_rob_id_i [2],
    input  logic [DATA_WIDTH-1:0] cdb_data_i [2],
    input  logic [1:0]            cdb_exc_i,

    output rob_cnt_t              rob_free_o,

    // head view for commit
    input  logic [1:0]            commit_req_i,
    output logic [1:0]            head_valid_o,
    output logic [AREG_WIDTH-1:0] head_areg_o [2],
    output logic [1:0]            head_w_reg_o,
    output logic [PC_WIDTH-1:0]   head_pc_o [2],
    output logic [DATA_WIDTH-1:0] head_data_o [2],
    output logic [1:0]            head_exc_o
);

    rob_id_t         tail [2];
    rob_cnt_t        count;
    rob_inst_entry_t disp_inst [2];
    rob_inst_entry_t head_inst [2];
    rob_data_entry_t cdb_entry [2];
    rob_id_t         rd_addr   [6];
    rob_data_entry_t rd_data   [6];
    logic [5:0]      rd_complete;

    rob_pointers i_pointers (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .commit_req_i     (commit_req_i),
        .tail_o           (tail),
        .count_o          (count),
        .free_o           (rob_free_o)
    );

    ////////////////////////////////
    // packing and read addresses
    ////////////////////////////////

    // read ports 0..1 are the two oldest entries, 2..5 the sources
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            disp_inst[k].areg  = dispatch_areg_i[k];
            disp_inst[k].w_reg = dispatch_w_reg_i[k];
            disp_inst[k].pc    = dispatch_pc_i[k];
            cdb_entry[k].data  = cdb_data_i[k];
            cdb_entry[k].exc   = cdb_exc_i[k];
            rd_addr[k]         = tail[k];
        end
        for (int s = 0; s < 4; s++) begin
            rd_addr[2+s] = src_rob_id_i[s];
        end
    end

    multiport_table #(.payload_t(rob_inst_entry_t), .RD_PORTS(2)) i_inst_table (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (flush_i),
        .raddr_i (tail),
        .rdata_o (head_inst),
        .waddr_i (dispatch_rob_id_i),
        .we_i    (dispatch_valid_i),
        .wdata_i (disp_inst)
    );

    multiport_table #(.payload_t(rob_data_entry_t), .RD_PORTS(6)) i_data_table (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (flush_i),
        .raddr_i (rd_addr),
        .rdata_o (rd_data),
        .waddr_i (cdb_rob_id_i),
        .we_i    (cdb_valid_i),
        .wdata_i (cdb_entry)
    );

    complete_table #(.RD_PORTS(6)) i_complete_table (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .clear_i     (flush_i),
        .disp_addr_i (dispatch_rob_id_i),
        .disp_we_i   (dispatch_valid_i),
        .cdb_addr_i  (cdb_rob_id_i),
        .cdb_we_i    (cdb_valid_i),
        .raddr_i     (rd_addr),
        .complete_o  (rd_complete)
    );

    ////////////////////////////////
    // outputs
    ////////////////////////////////

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            // slot k needs more than k entries present
            head_valid_o[k] = rd_complete[k] && (count > rob_cnt_t'(k));
            head_areg_o[k]  = head_inst[k].areg;
            head_w_reg_o[k] = head_inst[k].w_reg;
            head_pc_o[k]    = head_inst[k].pc;
            head_data_o[k]  = rd_data[k].data;
            head_exc_o[k]   = rd_data[k].exc;
        end
        for (int s = 0; s < 4; s++) begin
            src_data_o[s]  = rd_data[2+s].data;
            src_ready_o[s] = rd_complete[2+s];
        end
    end

endmodule

/* src/rob_pointers.sv */
module rob_pointers
    import rob_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     [1:0] dispatch_valid_i,
    input  logic     [1:0] commit_req_i,

    output rob_id_t  tail_o [2],
    output rob_cnt_t count_o,
    output rob_cnt_t free_o
);

    rob_id_t  head_q;
    rob_cnt_t count_q;
    rob_cnt_t n_disp;
    rob_cnt_t n_commit;

    assign n_disp   = rob_cnt_t'(dispatch_valid_i[0]) + rob_cnt_t'(dispatch_valid_i[1]);
    assign n_commit = rob_cnt_t'(commit_req_i[0]) + rob_cnt_t'(commit_req_i[1]);

    // oldest index wraps mod 16 on its own
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + rob_id_t'(n_commit);
            count_q <= count_q + n_disp - n_commit;
        end
    end

    // two oldest entries
    assign tail_o[0] = head_q;
    assign tail_o[1] = head_q + rob_id_t'(1);

    assign count_o = count_q;
    assign free_o  = rob_cnt_t'(ROB_DEPTH) - count_q;

endmodule

/* src/complete_table.sv */
module complete_table
    import rob_cfg_pkg::*;
#(
    parameter int RD_PORTS = 6
) (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    clear_i,

    input  rob_id_t disp_addr_i [2],
    input  logic    [1:0] disp_we_i,

    input  rob_id_t cdb_addr_i [2],
    input  logic    [1:0] cdb_we_i,

    input  rob_id_t raddr_i [RD_PORTS],
    output logic    [RD_PORTS-1:0] complete_o
);

    // the extra two ports look up the other table's bit
    // for the entries being written this cycle
    rob_id_t disp_raddr [RD_PORTS+2];
    rob_id_t wb_raddr   [RD_PORTS+2];
    logic    disp_bit   [RD_PORTS+2];
    logic    wb_bit     [RD_PORTS+2];
    logic    disp_wdata [2];
    logic    wb_wdata   [2];

    always_comb begin
        for (int r = 0; r < RD_PORTS; r++) begin
            disp_raddr[r] = raddr_i[r];
            wb_raddr[r]   = raddr_i[r];
        end
        for (int k = 0; k < 2; k++) begin
            disp_raddr[RD_PORTS+k] = cdb_addr_i[k];
            wb_raddr[RD_PORTS+k]   = disp_addr_i[k];
            // dispatch copies the wb bit, so the pair starts equal
            disp_wdata[k] = wb_bit[RD_PORTS+k];
            // writeback flips against the dispatch bit
            wb_wdata[k]   = ~disp_bit[RD_PORTS+k];
        end
        for (int r = 0; r < RD_PORTS; r++) begin
            complete_o[r] = disp_bit[r] ^ wb_bit[r];
        end
    end

    multiport_table #(.payload_t(logic), .RD_PORTS(RD_PORTS + 2)) i_disp_table (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (clear_i),
        .raddr_i (disp_raddr),
        .rdata_o (disp_bit),
        .waddr_i (disp_addr_i),
        .we_i    (disp_we_i),
        .wdata_i (disp_wdata)
    );

    multiport_table #(.payload_t(logic), .RD_PORTS(RD_PORTS + 2)) i_wb_table (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (clear_i),
        .raddr_i (wb_raddr),
        .rdata_o (wb_bit),
        .waddr_i (cdb_addr_i),
        .we_i    (cdb_we_i),
        .wdata_i (wb_wdata)
    );

endmodule

/* src/multiport_table.sv */
module multiport_table
    import rob_cfg_pkg::*;
#(
    parameter type payload_t = logic,
    parameter int  RD_PORTS  = 2
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     clear_i,

    // asynchronous read ports
    input  rob_id_t  raddr_i [RD_PORTS],
    output payload_t rdata_o [RD_PORTS],

    // two synchronous write ports
    input  rob_id_t  waddr_i [2],
    input  logic     [1:0] we_i,
    input  payload_t wdata_i [2]
);

    payload_t mem [ROB_DEPTH];

    ////////////////////////////////
    // write side
    ////////////////////////////////

    // port 1 comes last in the loop and so wins
    // when both ports hit one address
    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (we_i[p]) begin
                    mem[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    ////////////////////////////////
    // read side
    ////////////////////////////////

    // reads see the state before this edge
    always_comb begin
        for (int r = 0; r < RD_PORTS; r++) begin
            rdata_o[r] = mem[raddr_i[r]];
        end
    end

endmodule

/* src/rob_entry_pkg.sv */
package rob_entry_pkg;

    import rob_cfg_pkg::*;

    ////////////////////////////////
    // instruction table payload
    ////////////////////////////////

    // written once at dispatch, read at commit
    typedef struct packed {
        logic [AREG_WIDTH-1:0] areg;
        logic                  w_reg;
        logic [PC_WIDTH-1:0]   pc;
    } rob_inst_entry_t;

    ////////////////////////////////
    // data table payload
    ////////////////////////////////

    // written by a result bus
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  exc;
    } rob_data_entry_t;

    // layout
    //   inst : | areg | w_reg | pc |
    //   data : | data | exc |
    // both tables are indexed by rob_id_t
    // and hold ROB_DEPTH entries each
    // completion is kept apart from these,
    // see complete_table

endpackage

/* src/rob_cfg_pkg.sv */
package rob_cfg_pkg;

    ////////////////////////////////
    // sizes
    ////////////////////////////////

    // 16 entries, 4-bit index
    localparam int ROB_WIDTH  = 4;
    localparam int ROB_DEPTH  = 1 << ROB_WIDTH;

    // architectural register index
    localparam int AREG_WIDTH = 5;

    // data path
    localparam int DATA_WIDTH = 32;
    localparam int PC_WIDTH   = 32;

    // entry index into the ROB
    typedef logic [ROB_WIDTH-1:0] rob_id_t;

    // one extra bit so a full ROB can be counted
    typedef logic [ROB_WIDTH:0] rob_cnt_t;

endpackage
